/* files.f */
mem_pkg.sv
dcache_array.sv
dcache_ctrl.sv
ifetch_unit.sv
mem_arbiter.sv
tagged_memory.sv
mem_subsystem_top.sv
tb_clock_gen.sv
mem_subsystem_props.sv
mem_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_subsystem_tb \
  -f files.f \
  -o Vmem_subsystem_tb

./obj_dir/Vmem_subsystem_tb

/* mem_subsystem_tb.sv */
// memory subsystem testbench: directed and random load/store traffic, fetches and halt
`default_nettype none
`timescale 1ns/100ps

module mem_subsystem_tb import mem_pkg::*; ();

  localparam int DIR_REQS = 11;
  localparam int RAND_REQS = 100;
  localparam int FETCHES = 4;
  localparam int NUM_PR = 1 << PR_BITS;
  localparam int WATCHDOG_CYCLES =
    (DIR_REQS + RAND_REQS + FETCHES) * (QUEUE_DEPTH + MEM_LATENCY + 4) + 16 + 64;

  logic        clock;
  logic        reset;
  logic        req_valid;
  lsq_req_t    req;
  logic        req_ready;
  cdb_result_t cdb;
  logic        halt_req;
  logic        halt_done;
  logic        fetch_valid;
  mem_addr_t   fetch_pc;
  logic        fetch_ready;
  logic        instr_valid;
  logic [63:0] instr_data;

  logic [63:0]        shadow [MEM_WORDS];  // memory as the program sees it
  logic               pending [NUM_PR];
  logic [63:0]        exp_data [NUM_PR];
  logic [AR_BITS-1:0] exp_ar [NUM_PR];
  logic               want_hit [NUM_PR];
  int                 acc_cycle [NUM_PR];
  int                 outstanding;
  int                 next_pr;
  int                 cycle;
  logic [31:0]        lfsr;

  tb_clock_gen clkgen0 (.clock(clock), .reset(reset));

  mem_subsystem_top dut0 (
    .clock(clock), .reset(reset), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .cdb(cdb), .halt_req(halt_req), .halt_done(halt_done), .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc), .fetch_ready(fetch_ready), .instr_valid(instr_valid),
    .instr_data(instr_data)
  );

  bind dcache_ctrl mem_subsystem_props props0 (
    .clock(clock), .reset(reset), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .cmd_valid(cmd_valid), .cmd(cmd), .grant(grant), .resp_tag(resp_tag), .cdb(cdb),
    .halt_done(halt_done)
  );

  always @(posedge clock)
    cycle <= cycle + 1;

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[62:0], fb};
    end
    return bits;
  endfunction

  // expected memory word for an address
  function automatic logic [63:0] ref_word(input mem_addr_t addr);
    return shadow[addr.w.word[MEM_AW-1:0]];
  endfunction

  function automatic mem_addr_t word_addr(input logic [7:0] word);
    mem_addr_t a;
    a        = '0;
    a.w.word = WORD_BITS'(word);
    return a;
  endfunction

  // called on a falling edge, returns on a falling edge after acceptance
  task automatic send_req(input logic is_store, input logic [7:0] word,
                          input logic [63:0] data, input logic hit_expected,
                          output int pr);
    lsq_req_t r;
    r          = '0;
    r.is_store = is_store;
    r.addr     = word_addr(word);
    r.data     = data;
    r.pr       = PR_BITS'(next_pr);
    r.ar       = AR_BITS'(next_pr * 7);
    pr         = next_pr;
    next_pr    = next_pr + 1;
    req_valid  = 1'b1;
    req        = r;
    // req_ready depends on registers only, settled on the falling edge
    while (!req_ready)
      @(negedge clock);
    if (is_store)
      shadow[word] = data;  // later loads must see it
    else
    begin
      exp_data[pr]  = ref_word(r.addr);
      exp_ar[pr]    = r.ar;
      want_hit[pr]  = hit_expected;
      acc_cycle[pr] = cycle;
      pending[pr]   = 1'b1;
      outstanding   = outstanding + 1;
    end
    @(negedge clock);  // taken on the rising edge in between
    req_valid = 1'b0;
  endtask

  task automatic wait_result(input int pr);
    @(posedge clock);
    while (pending[pr])
      @(posedge clock);
    @(negedge clock);
  endtask

  task automatic directed_tests();
    int p;
    int p_load;
    send_req(1'b0, 8'd3, '0, 1'b0, p);  // cold miss
    wait_result(p);
    send_req(1'b0, 8'd3, '0, 1'b1, p);
    send_req(1'b1, 8'd3, 64'h0123_4567_89ab_cdef, 1'b0, p);  // store hit
    send_req(1'b0, 8'd3, '0, 1'b1, p);
    send_req(1'b1, 8'd5, 64'hfeed_0000_5555_0005, 1'b0, p);  // store miss, no allocate
    send_req(1'b0, 8'd5, '0, 1'b0, p);
    // store right behind a load miss of the same word, the old fill must not stick
    send_req(1'b0, 8'd6, '0, 1'b0, p_load);
    send_req(1'b1, 8'd6, 64'h6666_aaaa_6666_aaaa, 1'b0, p);
    wait_result(p_load);
    send_req(1'b0, 8'd6, '0, 1'b0, p);
    // word outside the random range, fetched later
    send_req(1'b1, 8'd100, 64'hc0de_1000_c0de_1000, 1'b0, p);
    send_req(1'b0, 8'd100, '0, 1'b0, p);
    wait_result(p);
  endtask

  task automatic random_stream();
    logic [63:0] bits;
    logic        is_store;
    logic [7:0]  word;
    logic [63:0] data;
    int          p;
    for (int i = 0; i < RAND_REQS; i++)
    begin
      bits     = rand_bits(1);
      is_store = bits[0];
      bits     = rand_bits(4);
      word     = {2'b00, bits[3], 2'b00, bits[2:0]};  // two tags per index
      data     = '0;
      if (is_store)
        data = rand_bits(64);
      send_req(is_store, word, data, 1'b0, p);
    end
  endtask

  task automatic fetch_word(input logic [7:0] word);
    logic [63:0] exp_word;
    fetch_pc    = word_addr(word);
    fetch_valid = 1'b1;
    while (!fetch_ready)
      @(negedge clock);
    exp_word = ref_word(fetch_pc);
    @(negedge clock);
    fetch_valid = 1'b0;
    while (!instr_valid)
      @(negedge clock);
    assert (instr_data == exp_word)
    else
    begin
      $display("Error: instr_data = %h, expected %h", instr_data, exp_word);
      stop_with_failure();
    end
  endtask

  task automatic fetch_sequence();
    fetch_word(8'd100);
    fetch_word(8'd101);
    fetch_word(8'd200);
    fetch_word(8'd100);
  endtask

  task automatic halt_check();
    lsq_req_t r;
    r           = '0;
    r.addr      = word_addr(8'd1);
    r.pr        = PR_BITS'(next_pr);  // never to be accepted
    halt_req    = 1'b1;
    req_valid   = 1'b1;
    req         = r;
    while (!halt_done)
      @(negedge clock);
    assert ((outstanding == 0) && !cdb.valid)
    else
    begin
      $display("halt_done rose before every outstanding load had returned its result");
      stop_with_failure();
    end
    repeat (4)
    begin
      @(negedge clock);
      assert (!req_ready)
      else
      begin
        $display("Error: req_ready = %h after halt, expected %h", req_ready, 1'b0);
        stop_with_failure();
      end
    end
  endtask

  // checks every result bus entry against the record of its pr
  always @(negedge clock)
  begin
    if (cdb.valid)
    begin
      assert (pending[cdb.pr])
      else
      begin
        $display("result for pr %0d was never requested or came twice", cdb.pr);
        stop_with_failure();
      end
      assert (cdb.data == exp_data[cdb.pr])
      else
      begin
        $display("Error: cdb.data = %h, expected %h", cdb.data, exp_data[cdb.pr]);
        stop_with_failure();
      end
      assert (cdb.ar == exp_ar[cdb.pr])
      else
      begin
        $display("Error: cdb.ar = %h, expected %h", cdb.ar, exp_ar[cdb.pr]);
        stop_with_failure();
      end
      if (want_hit[cdb.pr])
      begin
        assert (cycle == acc_cycle[cdb.pr] + 1)
        else
        begin
          $display("load hit for pr %0d answered %0d cycles after acceptance",
                   cdb.pr, cycle - acc_cycle[cdb.pr]);
          stop_with_failure();
        end
      end
      pending[cdb.pr] = 1'b0;
      outstanding     = outstanding - 1;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES)
      @(posedge clock);
    $display("watchdog expired after %0d cycles, a response never arrived",
             WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial
  begin
    req_valid   = 1'b0;
    req         = '0;
    halt_req    = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    lfsr        = 32'hb8dd;
    for (int n = 0; n < MEM_WORDS; n++)
      shadow[n] = 64'(n) ^ MEM_INIT_PATTERN;  // power-up contents
    for (int n = 0; n < NUM_PR; n++)
      pending[n] = 1'b0;
    @(posedge clock);
    while (reset)
      @(posedge clock);
    @(negedge clock);
    directed_tests();
    fork
      random_stream();
      fetch_sequence();
    join
    halt_check();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* mem_subsystem_props.sv */
// handshake, reset and halt properties of the data cache controller
`default_nettype none
`timescale 1ns/100ps

module mem_subsystem_props import mem_pkg::*; (
  input logic        clock,
  input logic        reset,
  input logic        req_valid,
  input lsq_req_t    req,
  input logic        req_ready,
  input logic        cmd_valid,
  input mem_cmd_t    cmd,
  input logic        grant,
  input mem_tag_t    resp_tag,
  input cdb_result_t cdb,
  input logic        halt_done
);

  // a waiting request is held as it is
  req_hold: assert property (@(posedge clock) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("load/store request changed before it was accepted");

  // queue head stays on the bus until memory takes it
  cmd_hold: assert property (@(posedge clock) disable iff (reset)
    cmd_valid && !(grant && (resp_tag != '0)) |=> cmd_valid && $stable(cmd))
    else $error("memory command changed before it was granted");

  reset_quiet: assert property (@(posedge clock)
    reset |=> !cdb.valid && !halt_done && !req_ready && !cmd_valid)
    else $error("controller outputs active right after reset");

  halt_sticky: assert property (@(posedge clock) disable iff (reset)
    halt_done |=> halt_done)
    else $error("halt_done fell without a reset");

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// testbench clock and synchronous reset source
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever
      #10 clock = ~clock;  // 20 ns period
  end

  // held for the first 16 rising edges, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (16)
      @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* mem_subsystem_top.sv */
// memory subsystem top: cache controller, cache array, fetch unit, arbiter, memory
`default_nettype none
`timescale 1ns/100ps

module mem_subsystem_top import mem_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  lsq_req_t    req,
  output logic        req_ready,
  output cdb_result_t cdb,
  input  logic        halt_req,
  output logic        halt_done,
  input  logic        fetch_valid,
  input  mem_addr_t   fetch_pc,
  output logic        fetch_ready,
  output logic        instr_valid,
  output logic [63:0] instr_data
);

  mem_addr_t   rd_addr;
  logic        rd_hit;
  logic [63:0] rd_data;
  logic        wr_en;
  mem_addr_t   wr_addr;
  logic [63:0] wr_data;
  logic        dc_cmd_valid;
  mem_cmd_t    dc_cmd;
  logic        dc_grant;
  mem_tag_t    dc_resp_tag;
  logic        if_cmd_valid;
  mem_cmd_t    if_cmd;
  logic        if_grant;
  mem_tag_t    if_resp_tag;
  logic        mem_cmd_valid;
  mem_cmd_t    mem_cmd;
  logic        mem_ready;
  mem_tag_t    mem_tag;
  mem_ret_t    mem_ret;  // broadcast to both peers

  dcache_ctrl ctrl0 (
    .clock(clock), .reset(reset), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .halt_req(halt_req), .halt_done(halt_done), .rd_addr(rd_addr), .rd_hit(rd_hit),
    .rd_data(rd_data), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .cmd_valid(dc_cmd_valid), .cmd(dc_cmd), .grant(dc_grant), .resp_tag(dc_resp_tag),
    .ret(mem_ret), .cdb(cdb)
  );

  dcache_array array0 (
    .clock(clock), .reset(reset), .rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr),
    .wr_data(wr_data), .rd_hit(rd_hit), .rd_data(rd_data)
  );

  ifetch_unit fetch0 (
    .clock(clock), .reset(reset), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .fetch_ready(fetch_ready), .cmd_valid(if_cmd_valid), .cmd(if_cmd), .grant(if_grant),
    .resp_tag(if_resp_tag), .ret(mem_ret), .instr_valid(instr_valid),
    .instr_data(instr_data)
  );

  mem_arbiter arb0 (
    .clock(clock), .reset(reset), .dc_cmd_valid(dc_cmd_valid), .dc_cmd(dc_cmd),
    .dc_grant(dc_grant), .dc_resp_tag(dc_resp_tag), .if_cmd_valid(if_cmd_valid),
    .if_cmd(if_cmd), .if_grant(if_grant), .if_resp_tag(if_resp_tag),
    .mem_ready(mem_ready), .mem_tag(mem_tag), .mem_cmd_valid(mem_cmd_valid),
    .mem_cmd(mem_cmd)
  );

  tagged_memory mem0 (
    .clock(clock), .reset(reset), .cmd_valid(mem_cmd_valid), .cmd(mem_cmd),
    .cmd_ready(mem_ready), .tag(mem_tag), .ret(mem_ret)
  );

endmodule

`default_nettype wire

/* tagged_memory.sv */
// main memory with per-command transaction tags and a fixed return latency
`default_nettype none
`timescale 1ns/100ps

module tagged_memory import mem_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     cmd_valid,
  input  mem_cmd_t cmd,
  output logic     cmd_ready,
  output mem_tag_t tag,
  output mem_ret_t ret
);

  logic [63:0]           mem [MEM_WORDS];
  mem_ret_t              pipe [MEM_LATENCY];
  logic [NUM_MEM_TAGS:1] busy;
  mem_tag_t              free_tag;
  logic                  accept;
  logic [MEM_AW-1:0]     widx;

  initial
  begin
    for (int n = 0; n < MEM_WORDS; n++)
      mem[n] = 64'(n) ^ MEM_INIT_PATTERN;
  end

  // lowest free tag, 0 when all are in flight
  always_comb
  begin
    free_tag = '0;
    for (int i = NUM_MEM_TAGS; i >= 1; i--)
      if (!busy[i])
        free_tag = mem_tag_t'(i);
  end

  assign cmd_ready = (free_tag != '0);
  assign accept    = cmd_valid & cmd_ready;
  assign tag       = accept ? free_tag : '0;
  assign widx      = cmd.addr.w.word[MEM_AW-1:0];  // upper word bits ignored
  assign ret       = pipe[MEM_LATENCY-1];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      busy <= '0;
      for (int i = 0; i < MEM_LATENCY; i++)
        pipe[i].valid <= 1'b0;
    end
    else
    begin
      if (ret.valid)
        busy[ret.tag] <= 1'b0;  // tag reusable from the next cycle
      if (accept)
        busy[free_tag] <= 1'b1;
      pipe[0].valid <= accept;
      pipe[0].tag   <= free_tag;
      pipe[0].data  <= (cmd.cmd == BUS_STORE) ? cmd.data : mem[widx];
      for (int i = 1; i < MEM_LATENCY; i++)
        pipe[i] <= pipe[i-1];
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept && (cmd.cmd == BUS_STORE))
      mem[widx] <= cmd.data;
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
// round-robin arbiter between the data cache and fetch unit on the memory bus
`default_nettype none
`timescale 1ns/100ps

module mem_arbiter import mem_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     dc_cmd_valid,
  input  mem_cmd_t dc_cmd,
  output logic     dc_grant,
  output mem_tag_t dc_resp_tag,
  input  logic     if_cmd_valid,
  input  mem_cmd_t if_cmd,
  output logic     if_grant,
  output mem_tag_t if_resp_tag,
  input  logic     mem_ready,
  input  mem_tag_t mem_tag,
  output logic     mem_cmd_valid,
  output mem_cmd_t mem_cmd
);

  logic last_dc;  // data cache won the last grant

  // on a tie the side that lost last time goes first
  assign dc_grant = mem_ready & dc_cmd_valid & (~if_cmd_valid | ~last_dc);
  assign if_grant = mem_ready & if_cmd_valid & (~dc_cmd_valid | last_dc);

  assign mem_cmd_valid = dc_grant | if_grant;
  assign mem_cmd       = dc_grant ? dc_cmd : if_cmd;

  // the loser sees tag 0
  assign dc_resp_tag = dc_grant ? mem_tag : '0;
  assign if_resp_tag = if_grant ? mem_tag : '0;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      last_dc <= 1'b0;
    end
    else if (mem_cmd_valid)
    begin
      last_dc <= dc_grant;
    end
  end

endmodule

`default_nettype wire

/* ifetch_unit.sv */
// instruction fetch peer with a single outstanding memory load
`default_nettype none
`timescale 1ns/100ps

module ifetch_unit import mem_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  input  mem_addr_t   fetch_pc,
  output logic        fetch_ready,
  output logic        cmd_valid,
  output mem_cmd_t    cmd,
  input  logic        grant,
  input  mem_tag_t    resp_tag,
  input  mem_ret_t    ret,
  output logic        instr_valid,
  output logic [63:0] instr_data
);

  typedef enum logic [1:0] {IF_OFF, IF_IDLE, IF_REQ, IF_WAIT} if_state_t;

  if_state_t state;
  mem_addr_t pc_q;
  mem_tag_t  tag_q;

  assign fetch_ready = (state == IF_IDLE);
  assign cmd_valid   = (state == IF_REQ);

  always_comb
  begin
    cmd.cmd  = cmd_valid ? BUS_LOAD : BUS_NONE;
    cmd.addr = pc_q;
    cmd.data = '0;  // fetches never write
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state       <= IF_OFF;
      instr_valid <= 1'b0;
    end
    else
    begin
      instr_valid <= 1'b0;
      case (state)
        IF_OFF:  state <= IF_IDLE;
        IF_IDLE:
          if (fetch_valid)
          begin
            pc_q  <= fetch_pc;
            state <= IF_REQ;
          end
        IF_REQ:
          if (grant && (resp_tag != '0))
          begin
            tag_q <= resp_tag;  // claim only this return
            state <= IF_WAIT;
          end
        IF_WAIT:
          if (ret.valid && (ret.tag == tag_q))
          begin
            instr_valid <= 1'b1;
            instr_data  <= ret.data;
            state       <= IF_IDLE;
          end
        default: state <= IF_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
// non-blocking data cache controller with command queue, miss table and result bus
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl import mem_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  lsq_req_t    req,
  output logic        req_ready,
  input  logic        halt_req,
  output logic        halt_done,
  output mem_addr_t   rd_addr,
  input  logic        rd_hit,
  input  logic [63:0] rd_data,
  output logic        wr_en,
  output mem_addr_t   wr_addr,
  output logic [63:0] wr_data,
  output logic        cmd_valid,
  output mem_cmd_t    cmd,
  input  logic        grant,
  input  mem_tag_t    resp_tag,
  input  mem_ret_t    ret,
  output cdb_result_t cdb
);

  // command queue
  lsq_req_t               q_req [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] q_fill;          // load may still write the cache
  logic [QPTR_BITS-1:0]   head;
  logic [QPTR_BITS-1:0]   tail;
  logic [QPTR_BITS:0]     count;

  // miss table, indexed by memory tag
  lsq_req_t               t_req [1:NUM_MEM_TAGS];
  logic [NUM_MEM_TAGS:1]  t_busy;
  logic [NUM_MEM_TAGS:1]  t_fill;

  logic     live;                          // one idle cycle after reset
  logic     halt_pend;
  logic     accept;
  logic     load_hit;
  logic     enqueue;
  logic     issue;
  logic     ret_hit;
  logic     ret_load;
  logic     stale_head;
  lsq_req_t head_req;

  assign head_req = q_req[head];
  assign rd_addr  = req.addr;
  assign accept   = req_valid & req_ready;
  assign load_hit = accept & ~req.is_store & rd_hit;
  assign enqueue  = accept & (req.is_store | ~rd_hit);  // misses and all stores
  assign issue    = grant && (resp_tag != '0);
  assign ret_hit  = ret.valid && (ret.tag != '0) && t_busy[ret.tag];
  assign ret_load = ret_hit && !t_req[ret.tag].is_store;

  // store overtaking a load at the queue head in this very cycle
  assign stale_head = accept & req.is_store & ~head_req.is_store &
                      (head_req.addr.w.word == req.addr.w.word);

  // a load fill owns the result bus and the write port
  assign req_ready = live & (count != (QPTR_BITS+1)'(QUEUE_DEPTH)) & ~ret_load &
                     ~halt_pend & ~halt_req;

  assign cmd_valid = (count != '0);

  always_comb
  begin
    cmd.cmd  = cmd_valid ? (head_req.is_store ? BUS_STORE : BUS_LOAD) : BUS_NONE;
    cmd.addr = head_req.addr;
    cmd.data = head_req.data;
  end

  // fill has priority, a hitting store writes through otherwise
  always_comb
  begin
    wr_en   = 1'b0;
    wr_addr = req.addr;
    wr_data = req.data;
    if (ret_load && t_fill[ret.tag])
    begin
      wr_en   = 1'b1;
      wr_addr = t_req[ret.tag].addr;
      wr_data = ret.data;
    end
    else if (accept && req.is_store && rd_hit)
    begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      live      <= 1'b0;
      halt_pend <= 1'b0;
      halt_done <= 1'b0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      t_busy    <= '0;
      cdb.valid <= 1'b0;
    end
    else
    begin
      live      <= 1'b1;
      halt_pend <= halt_pend | halt_req;
      halt_done <= halt_done | (halt_pend & (count == '0) & ~|t_busy);  // sticky
      if (enqueue)
        tail <= tail + 1'b1;
      if (issue)
        head <= head + 1'b1;
      case ({enqueue, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (ret_hit)
        t_busy[ret.tag] <= 1'b0;
      if (issue)
        t_busy[resp_tag] <= 1'b1;  // memory never hands out a busy tag
      cdb.valid <= ret_load | load_hit;
      if (ret_load)
      begin
        cdb.pr   <= t_req[ret.tag].pr;
        cdb.ar   <= t_req[ret.tag].ar;
        cdb.data <= ret.data;
      end
      else if (load_hit)
      begin
        cdb.pr   <= req.pr;
        cdb.ar   <= req.ar;
        cdb.data <= rd_data;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (enqueue)
    begin
      q_req[tail]  <= req;
      q_fill[tail] <= ~req.is_store;
    end
    if (issue)
    begin
      t_req[resp_tag]  <= head_req;
      t_fill[resp_tag] <= q_fill[head] & ~stale_head;
    end
    // a newer store makes pending fills of its word stale
    if (accept && req.is_store)
    begin
      for (int i = 0; i < QUEUE_DEPTH; i++)
        if (q_req[i].addr.w.word == req.addr.w.word)
          q_fill[i] <= 1'b0;
      for (int i = 1; i <= NUM_MEM_TAGS; i++)
        if (t_busy[i] && (t_req[i].addr.w.word == req.addr.w.word))
          t_fill[i] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* dcache_array.sv */
// direct-mapped data cache store with one combinational read and one write port
`default_nettype none
`timescale 1ns/100ps

module dcache_array import mem_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  mem_addr_t   rd_addr,
  input  logic        wr_en,
  input  mem_addr_t   wr_addr,
  input  logic [63:0] wr_data,
  output logic        rd_hit,
  output logic [63:0] rd_data
);

  logic [TAG_BITS-1:0] tag_mem [LINES];
  logic [63:0]         data_mem [LINES];
  logic [LINES-1:0]    valid;

  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;

  assign rd_idx = rd_addr.f.idx;
  assign wr_idx = wr_addr.f.idx;

  // hit needs a live line with the same tag
  assign rd_hit  = valid[rd_idx] && (tag_mem[rd_idx] == rd_addr.f.tag);
  assign rd_data = data_mem[rd_idx];

  // only the valid bits are cleared
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid <= '0;
    end
    else if (wr_en)
    begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]  <= wr_addr.f.tag;  // line now belongs to this address
      data_mem[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* mem_pkg.sv */
// memory subsystem package: address union, bus structs and sizing constants
`default_nettype none

package mem_pkg;

  localparam int ADDR_BITS = 16;           // byte address
  localparam int OFS_BITS = 3;             // byte offset in a 64-bit word
  localparam int WORD_BITS = ADDR_BITS - OFS_BITS;
  localparam int IDX_BITS = 5;
  localparam int LINES = 1 << IDX_BITS;
  localparam int TAG_BITS = ADDR_BITS - IDX_BITS - OFS_BITS;
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW = $clog2(MEM_WORDS);
  localparam int MEM_LATENCY = 6;          // acceptance to data return
  localparam int QUEUE_DEPTH = 8;          // power of two, pointers wrap
  localparam int QPTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int NUM_MEM_TAGS = 15;        // tag 0 means none
  localparam int PR_BITS = 7;
  localparam int AR_BITS = 5;
  localparam logic [63:0] MEM_INIT_PATTERN = 64'h5a3c_96e1_0f0f_c3a5;

  // same 16 bits, seen as a word address or as cache fields
  typedef union packed {
    struct packed {
      logic [WORD_BITS-1:0] word;
      logic [OFS_BITS-1:0]  offset;
    } w;
    struct packed {
      logic [TAG_BITS-1:0] tag;
      logic [IDX_BITS-1:0] idx;
      logic [OFS_BITS-1:0] offset;
    } f;
  } mem_addr_t;

  typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;

  typedef logic [3:0] mem_tag_t;

  typedef struct packed {
    logic               is_store;
    mem_addr_t          addr;
    logic [63:0]        data;
    logic [PR_BITS-1:0] pr;
    logic [AR_BITS-1:0] ar;
  } lsq_req_t;

  typedef struct packed {
    bus_cmd_t    cmd;
    mem_addr_t   addr;
    logic [63:0] data;
  } mem_cmd_t;

  typedef struct packed {
    logic        valid;
    mem_tag_t    tag;
    logic [63:0] data;
  } mem_ret_t;

  typedef struct packed {
    logic               valid;
    logic [PR_BITS-1:0] pr;
    logic [AR_BITS-1:0] ar;
    logic [63:0]        data;
  } cdb_result_t;

endpackage

`default_nettype wire
